// ==== common/arith_pkg.sv ====
package arith_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Operand and result width of the scalar unit
  localparam int DATA_WIDTH = 32;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  // One bit is enough for the two functions
  typedef enum logic {
    OP_SQRT = 1'b0,
    OP_DIV  = 1'b1
  } scalar_op_t;

  //////////////////////////////////////////////////
  // Request and result words
  //////////////////////////////////////////////////

  // Request sampled in the START cycle
  // operand_a is the radicand or the dividend
  // operand_b is the divisor, don't care for sqrt
  typedef struct packed {
    scalar_op_t            op;
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
  } scalar_request_t;

  // Registered outcome, stable until next READY
  // Overflow marks a negative radicand
  // or a zero divisor
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  overflow;
  } scalar_result_t;

endpackage

// ==== sqrt/scalar_sqrt_core.sv ====
`timescale 1ns/100ps

module scalar_sqrt_core #(
  parameter int DATA_SIZE = arith_pkg::DATA_WIDTH
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output logic                 OVERFLOW_OUT
);

  // One root bit per pair of radicand bits
  localparam int ROOT_W = DATA_SIZE / 2;
  // Room for the shifted remainder and trial value
  localparam int REM_W = ROOT_W + 2;
  localparam int CNT_W = $clog2(ROOT_W);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(ROOT_W - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ITER,
    ST_FINISH
  } sqrt_state_t;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // FSM and step counter
  sqrt_state_t      state;
  logic [CNT_W-1:0] step;
  logic             negative;

  // Iteration datapath
  logic [DATA_SIZE-1:0] radicand;
  logic [REM_W-1:0]     remainder;
  logic [ROOT_W-1:0]    root;

  // Next remainder candidate and trial subtrahend
  logic [REM_W-1:0] rem_shift;
  logic [REM_W-1:0] trial;
  logic             trial_fits;

  //////////////////////////////////////////////////
  // Digit step
  //////////////////////////////////////////////////

  // Bring down the top two radicand bits
  assign rem_shift  = {remainder[REM_W-3:0], radicand[DATA_SIZE-1 -: 2]};
  // Trial value 4*root + 1
  assign trial      = {root, 2'b01};
  assign trial_fits = (rem_shift >= trial);

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ST_IDLE;
      step     <= '0;
      negative <= 1'b0;
      READY    <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (START) begin
            state    <= ST_ITER;
            step     <= '0;
            // Sign bit decides the overflow path
            negative <= DATA_IN[DATA_SIZE-1];
          end
        end
        ST_ITER: begin
          step <= step + 1'b1;
          if (step == LAST_STEP) begin
            state <= ST_FINISH;
          end
        end
        ST_FINISH: begin
          READY <= 1'b1;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      ST_IDLE: begin
        if (START) begin
          radicand  <= DATA_IN;
          remainder <= '0;
          root      <= '0;
        end
      end
      ST_ITER: begin
        // Negative input only lets the counter run
        if (!negative) begin
          radicand <= radicand << 2;
          if (trial_fits) begin
            remainder <= rem_shift - trial;
            root      <= {root[ROOT_W-2:0], 1'b1};
          end else begin
            remainder <= rem_shift;
            root      <= {root[ROOT_W-2:0], 1'b0};
          end
        end
      end
      ST_FINISH: begin
        DATA_OUT     <= negative ? '0 : {{(DATA_SIZE - ROOT_W){1'b0}}, root};
        OVERFLOW_OUT <= negative;
      end
      default: ;
    endcase
  end

  // Single-cycle strobe
  a_ready_pulse : assert property (@(posedge CLK) disable iff (RST)
    READY |=> !READY);

  // A new START mid-run neither restarts nor stalls the count
  a_start_ignored : assert property (@(posedge CLK) disable iff (RST)
    (state == ST_ITER && START) |=> (state != ST_IDLE && step == $past(step) + 1'b1));

endmodule

// ==== divider/scalar_divider_core.sv ====
`timescale 1ns/100ps

module scalar_divider_core #(
  parameter int DATA_SIZE = arith_pkg::DATA_WIDTH
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] DIVIDEND_IN,
  input  logic [DATA_SIZE-1:0] DIVISOR_IN,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output logic                 OVERFLOW_OUT
);

  // One quotient bit per cycle
  localparam int CNT_W = $clog2(DATA_SIZE);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_SIZE - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ITER,
    ST_FINISH
  } div_state_t;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // FSM and bit counter
  div_state_t       state;
  logic [CNT_W-1:0] bit_cnt;
  logic             div_zero;

  // Dividend shifts out on top while quotient bits shift in below
  logic [DATA_SIZE-1:0] quotient;
  logic [DATA_SIZE-1:0] remainder;
  logic [DATA_SIZE-1:0] divisor;

  // Shift-subtract step
  logic [DATA_SIZE:0]   trial;
  logic [DATA_SIZE-1:0] diff;
  logic                 trial_fits;

  //////////////////////////////////////////////////
  // Shift-subtract step
  //////////////////////////////////////////////////

  // Partial remainder with next dividend bit appended
  assign trial      = {remainder, quotient[DATA_SIZE-1]};
  assign trial_fits = (trial >= {1'b0, divisor});
  // Low bits are exact whenever the trial fits
  assign diff       = trial[DATA_SIZE-1:0] - divisor;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ST_IDLE;
      bit_cnt  <= '0;
      div_zero <= 1'b0;
      READY    <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (START) begin
            state    <= ST_ITER;
            bit_cnt  <= '0;
            div_zero <= (DIVISOR_IN == '0);
          end
        end
        ST_ITER: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == LAST_BIT) begin
            state <= ST_FINISH;
          end
        end
        ST_FINISH: begin
          READY <= 1'b1;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      ST_IDLE: begin
        if (START) begin
          quotient  <= DIVIDEND_IN;
          divisor   <= DIVISOR_IN;
          remainder <= '0;
        end
      end
      ST_ITER: begin
        // Zero divisor holds the datapath, count still runs
        if (!div_zero) begin
          quotient <= {quotient[DATA_SIZE-2:0], trial_fits};
          if (trial_fits) begin
            remainder <= diff;
          end else begin
            remainder <= trial[DATA_SIZE-1:0];
          end
        end
      end
      ST_FINISH: begin
        // Saturate on divide by zero
        DATA_OUT     <= div_zero ? '1 : quotient;
        OVERFLOW_OUT <= div_zero;
      end
      default: ;
    endcase
  end

  // Single-cycle strobe
  a_ready_pulse : assert property (@(posedge CLK) disable iff (RST)
    READY |=> !READY);

endmodule

// ==== design/scalar_function_control.sv ====
`timescale 1ns/100ps

module scalar_function_control #(
  parameter int DATA_SIZE = arith_pkg::DATA_WIDTH
) (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  arith_pkg::scalar_request_t REQUEST,
  input  logic                      SQRT_READY,
  input  logic [DATA_SIZE-1:0]      SQRT_DATA,
  input  logic                      SQRT_OVERFLOW,
  input  logic                      DIV_READY,
  input  logic [DATA_SIZE-1:0]      DIV_DATA,
  input  logic                      DIV_OVERFLOW,
  output logic                      SQRT_START,
  output logic                      DIV_START,
  output logic [DATA_SIZE-1:0]      OPERAND_A,
  output logic [DATA_SIZE-1:0]      OPERAND_B,
  output logic                      READY,
  output logic                      BUSY,
  output arith_pkg::scalar_result_t RESULT
);

  import arith_pkg::*;

  // Opcode of the request in flight
  scalar_op_t pending_op;
  logic       accept;
  logic       core_done;

  //////////////////////////////////////////////////
  // Dispatch
  //////////////////////////////////////////////////

  // START while busy is dropped
  assign accept     = START && !BUSY;
  assign SQRT_START = accept && (REQUEST.op == OP_SQRT);
  assign DIV_START  = accept && (REQUEST.op == OP_DIV);

  // Cores capture operands in their start cycle
  assign OPERAND_A = REQUEST.operand_a;
  assign OPERAND_B = REQUEST.operand_b;

  // Only the pending core may finish the request
  assign core_done = BUSY && ((pending_op == OP_SQRT) ? SQRT_READY : DIV_READY);

  //////////////////////////////////////////////////
  // Busy tracking and result register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      BUSY       <= 1'b0;
      pending_op <= OP_SQRT;
      READY      <= 1'b0;
      RESULT     <= '0;
    end else begin
      READY <= 1'b0;
      if (accept) begin
        BUSY       <= 1'b1;
        pending_op <= REQUEST.op;
      end
      if (core_done) begin
        READY <= 1'b1;
        if (pending_op == OP_SQRT) begin
          RESULT <= '{data: SQRT_DATA, overflow: SQRT_OVERFLOW};
        end else begin
          RESULT <= '{data: DIV_DATA, overflow: DIV_OVERFLOW};
        end
      end
      // Busy covers the READY cycle too
      if (READY) begin
        BUSY <= 1'b0;
      end
    end
  end

  a_one_start : assert property (@(posedge CLK) disable iff (RST)
    !(SQRT_START && DIV_START));

  // Cores never finish without a request in flight
  a_ready_in_busy : assert property (@(posedge CLK) disable iff (RST)
    (SQRT_READY || DIV_READY) |-> BUSY);

endmodule

// ==== design/scalar_function_unit.sv ====
`timescale 1ns/100ps

module scalar_function_unit (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  arith_pkg::scalar_request_t REQUEST,
  output logic                      READY,
  output logic                      BUSY,
  output arith_pkg::scalar_result_t RESULT
);

  import arith_pkg::*;

  //////////////////////////////////////////////////
  // Control to cores
  //////////////////////////////////////////////////

  logic                  sqrt_start;
  logic                  div_start;
  logic [DATA_WIDTH-1:0] operand_a;
  logic [DATA_WIDTH-1:0] operand_b;

  //////////////////////////////////////////////////
  // Cores to control
  //////////////////////////////////////////////////

  logic                  sqrt_ready;
  logic [DATA_WIDTH-1:0] sqrt_data;
  logic                  sqrt_overflow;
  logic                  div_ready;
  logic [DATA_WIDTH-1:0] div_data;
  logic                  div_overflow;

  // Dispatch, merge and output register
  scalar_function_control #(
    .DATA_SIZE(DATA_WIDTH)
  ) i_control (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .REQUEST      (REQUEST),
    .SQRT_READY   (sqrt_ready),
    .SQRT_DATA    (sqrt_data),
    .SQRT_OVERFLOW(sqrt_overflow),
    .DIV_READY    (div_ready),
    .DIV_DATA     (div_data),
    .DIV_OVERFLOW (div_overflow),
    .SQRT_START   (sqrt_start),
    .DIV_START    (div_start),
    .OPERAND_A    (operand_a),
    .OPERAND_B    (operand_b),
    .READY        (READY),
    .BUSY         (BUSY),
    .RESULT       (RESULT)
  );

  // Radicand is operand_a
  scalar_sqrt_core #(
    .DATA_SIZE(DATA_WIDTH)
  ) i_sqrt (
    .CLK         (CLK),
    .RST         (RST),
    .START       (sqrt_start),
    .DATA_IN     (operand_a),
    .READY       (sqrt_ready),
    .DATA_OUT    (sqrt_data),
    .OVERFLOW_OUT(sqrt_overflow)
  );

  scalar_divider_core #(
    .DATA_SIZE(DATA_WIDTH)
  ) i_div (
    .CLK         (CLK),
    .RST         (RST),
    .START       (div_start),
    .DIVIDEND_IN (operand_a),
    .DIVISOR_IN  (operand_b),
    .READY       (div_ready),
    .DATA_OUT    (div_data),
    .OVERFLOW_OUT(div_overflow)
  );

endmodule

// ==== tests/scalar_function_unit_tb.sv ====
`timescale 1ns/100ps

module scalar_function_unit_tb;

  import arith_pkg::*;

  typedef logic [DATA_WIDTH-1:0] word_t;

  localparam int    CLK_HALF     = 20;
  localparam int    TIMEOUT      = 100;
  localparam int    RAND_COUNT   = 200;
  localparam int    SQRT_LATENCY = DATA_WIDTH / 2 + 2;
  localparam int    DIV_LATENCY  = DATA_WIDTH + 2;
  localparam word_t RAND_SEED    = 32'h5396_45db;
  localparam string TRACE_FILE   = "tests/scalar_function_trace.txt";

  logic            CLK;
  logic            RST;
  logic            START;
  scalar_request_t REQUEST;
  logic            READY;
  logic            BUSY;
  scalar_result_t  RESULT;

  // Test bookkeeping
  int pass_count;
  int fail_count;
  int test_errors;

  scalar_function_unit i_dut (
    .CLK    (CLK),
    .RST    (RST),
    .START  (START),
    .REQUEST(REQUEST),
    .READY  (READY),
    .BUSY   (BUSY),
    .RESULT (RESULT)
  );

  initial begin
    CLK = 1'b0;
    forever #CLK_HALF CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Floor root by bisection over the half-width root range
  function automatic word_t floor_sqrt(input word_t value);
    longint lo;
    longint hi;
    longint mid;
    lo = 0;
    hi = (longint'(1) << (DATA_WIDTH / 2)) - 1;
    while (lo < hi) begin
      mid = (lo + hi + 1) / 2;
      if (mid * mid <= longint'(value)) begin
        lo = mid;
      end else begin
        hi = mid - 1;
      end
    end
    return word_t'(lo);
  endfunction

  task automatic compute_expected(input scalar_op_t op, input word_t a, input word_t b,
                                  output word_t data, output logic ovf);
    if (op == OP_SQRT) begin
      // Radicand is signed
      ovf  = a[DATA_WIDTH-1];
      data = ovf ? '0 : floor_sqrt(a);
    end else if (b == '0) begin
      ovf  = 1'b1;
      data = '1;
    end else begin
      ovf  = 1'b0;
      data = a / b;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and response helpers
  //////////////////////////////////////////////////

  // One-cycle START, returns on the next falling edge
  task automatic drive_request(input scalar_op_t op, input word_t a, input word_t b);
    @(negedge CLK);
    START   = 1'b1;
    REQUEST = '{op: op, operand_a: a, operand_b: b};
    @(negedge CLK);
    START = 1'b0;
  endtask

  // Count rising edges until READY, noting any gap in BUSY
  task automatic wait_ready(input string name, inout int edges, output bit busy_gap);
    busy_gap = 1'b0;
    while (!READY && edges < TIMEOUT) begin
      if (!BUSY) busy_gap = 1'b1;
      @(negedge CLK);
      edges++;
    end
    if (!BUSY) busy_gap = 1'b1;
    if (!READY) begin
      $display("Timeout in test %s, no READY within %0d cycles", name, TIMEOUT);
      test_errors++;
    end
  endtask

  task automatic check_outcome(input string name, input word_t exp_data, input logic exp_ovf,
                               input int exp_edges, input int edges, input bit busy_gap);
    if (RESULT.data !== exp_data) begin
      $display("[ERROR] %s data expected %h actual %h", name, exp_data, RESULT.data);
      test_errors++;
    end
    if (RESULT.overflow !== exp_ovf) begin
      $display("[ERROR] %s overflow expected %b actual %b", name, exp_ovf, RESULT.overflow);
      test_errors++;
    end
    if (edges != exp_edges) begin
      $display("[ERROR] %s latency expected %0d actual %0d", name, exp_edges, edges);
      test_errors++;
    end
    if (busy_gap) begin
      $display("BUSY went low before READY in test %s", name);
      test_errors++;
    end
  endtask

  task automatic close_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s", name);
    end
    test_errors = 0;
  endtask

  task automatic run_test(input string name, input scalar_op_t op, input word_t a,
                          input word_t b, input word_t exp_data, input logic exp_ovf);
    int edges;
    bit busy_gap;
    edges = 0;
    drive_request(op, a, b);
    wait_ready(name, edges, busy_gap);
    check_outcome(name, exp_data, exp_ovf, (op == OP_SQRT) ? SQRT_LATENCY : DIV_LATENCY,
                  edges, busy_gap);
    close_test(name);
  endtask

  //////////////////////////////////////////////////
  // Test phases
  //////////////////////////////////////////////////

  task automatic run_trace();
    int               fd;
    int               fields;
    int               count;
    logic [8*128-1:0] line;
    logic [8*32-1:0]  name_buf;
    word_t            op_val;
    word_t            a;
    word_t            b;
    word_t            exp_data;
    word_t            exp_ovf;
    count = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TRACE_FILE);
      fail_count++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      fields = $sscanf(line, "%s %h %h %h %h %h", name_buf, op_val, a, b, exp_data, exp_ovf);
      // Comment and blank lines give fewer fields
      if (fields == 6) begin
        run_test($sformatf("%0s", name_buf), (op_val == '0) ? OP_SQRT : OP_DIV, a, b,
                 exp_data, exp_ovf[0]);
        count++;
      end
    end
    $fclose(fd);
    if (count == 0) begin
      $display("The trace file held no test lines");
      fail_count++;
    end
  endtask

  // Second START lands while the square root is running
  task automatic check_dropped_start();
    int edges;
    int quiet;
    bit busy_gap;
    bit extra_ready;
    drive_request(OP_SQRT, 32'h0000_0051, 32'h0);
    @(negedge CLK);
    START   = 1'b1;
    REQUEST = '{op: OP_DIV, operand_a: 32'h0000_0064, operand_b: 32'h0000_0005};
    @(negedge CLK);
    START = 1'b0;
    edges = 2;
    wait_ready("dropped_start", edges, busy_gap);
    check_outcome("dropped_start", 32'h0000_0009, 1'b0, SQRT_LATENCY, edges, busy_gap);
    // Window longer than a full divide
    extra_ready = 1'b0;
    for (quiet = 0; quiet < DIV_LATENCY + 8; quiet++) begin
      @(negedge CLK);
      if (READY || BUSY) extra_ready = 1'b1;
    end
    if (extra_ready) begin
      $display("A START issued while busy was not ignored in test dropped_start");
      test_errors++;
    end
    close_test("dropped_start");
  endtask

  task automatic run_random();
    scalar_op_t op;
    word_t      a;
    word_t      b;
    word_t      exp_data;
    logic       exp_ovf;
    for (int i = 0; i < RAND_COUNT; i++) begin
      op = ($urandom % 2 == 0) ? OP_SQRT : OP_DIV;
      // Mix full-range and shortened operands
      a = ($urandom % 2 == 0) ? $urandom : ($urandom >> ($urandom % 32));
      case ($urandom % 8)
        0:       b = '0;
        1, 2:    b = $urandom % 256;
        default: b = $urandom >> ($urandom % 32);
      endcase
      compute_expected(op, a, b, exp_data, exp_ovf);
      run_test($sformatf("random_%0d", i), op, a, b, exp_data, exp_ovf);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(RAND_SEED));
    pass_count  = 0;
    fail_count  = 0;
    test_errors = 0;
    START       = 1'b0;
    REQUEST     = '0;
    RST         = 1'b1;
    repeat (2) @(negedge CLK);
    RST = 1'b0;
    // Outputs idle straight after reset
    if (READY !== 1'b0 || BUSY !== 1'b0 || RESULT !== '0) begin
      $display("[ERROR] reset_state expected READY 0 BUSY 0 RESULT 0 actual %b %b %h",
               READY, BUSY, RESULT);
      test_errors++;
    end
    close_test("reset_state");
    run_trace();
    check_dropped_start();
    run_random();
    $display("Tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== tests/scalar_function_trace.txt ====
# name op operand_a operand_b exp_data exp_overflow
# op 0 is square root and 1 is divide, all values in hex
sqrt_zero            0 00000000 00000000 00000000 0
sqrt_one             0 00000001 00000000 00000001 0
sqrt_four            0 00000004 00000000 00000002 0
sqrt_81              0 00000051 00000000 00000009 0
sqrt_65536           0 00010000 00000000 00000100 0
sqrt_2_pow_30        0 40000000 00000000 00008000 0
sqrt_big_square      0 7ffea810 00000000 0000b504 0
sqrt_two             0 00000002 00000000 00000001 0
sqrt_eight           0 00000008 00000000 00000002 0
sqrt_99              0 00000063 00000000 00000009 0
sqrt_1000            0 000003e8 00000000 0000001f 0
sqrt_below_square    0 7ffea80f 00000000 0000b503 0
sqrt_below_2_pow_30  0 3fffffff 00000000 00007fff 0
sqrt_max_pos         0 7fffffff 00000000 0000b504 0
sqrt_b_ignored       0 00000090 00001234 0000000c 0
sqrt_min_neg         0 80000000 00000000 00000000 1
sqrt_minus_one       0 ffffffff 00000000 00000000 1
sqrt_neg_mid         0 c0000000 00000000 00000000 1
div_exact            1 00000064 00000005 00000014 0
div_trunc            1 00000064 00000007 0000000e 0
div_small            1 00000003 0000000a 00000000 0
div_zero_dividend    1 00000000 00000005 00000000 0
div_by_one_max       1 ffffffff 00000001 ffffffff 0
div_by_one           1 12345678 00000001 12345678 0
div_self             1 deadbeef deadbeef 00000001 0
div_half_max         1 ffffffff 00000002 7fffffff 0
div_pow2             1 80000000 00000010 08000000 0
div_by_3             1 000f4240 00000003 00051615 0
div_by_64k           1 ffffffff 00010000 0000ffff 0
div_by_zero          1 00000064 00000000 ffffffff 1
div_zero_by_zero     1 00000000 00000000 ffffffff 1

// ==== project.f ====
common/arith_pkg.sv
sqrt/scalar_sqrt_core.sv
divider/scalar_divider_core.sv
design/scalar_function_control.sv
design/scalar_function_unit.sv
tests/scalar_function_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the scalar function unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f project.f --top-module scalar_function_unit_tb -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -q "No errors"; then
  exit 0
fi
exit 1
